/* common/rom_pkg.sv */
package rom_pkg;

    localparam int SDRAM_AW = 22;           // Word address into SDRAM

    // Client address widths
    localparam int CHARW = 14;              // 16-bit words
    localparam int MAINW = 17;              // Bytes

    typedef logic [SDRAM_AW-1:0] sdram_addr_t;
    typedef logic [31:0]         sdram_data_t;
    typedef logic [15:0]         char_data_t;
    typedef logic [7:0]          main_data_t;

    // Memory map in SDRAM words
    localparam sdram_addr_t CPU_OFFSET  = 22'h0;
    localparam sdram_addr_t CHAR_OFFSET = 22'h1_4000;

    // Object graphics region, loaded with a reordered address
    localparam sdram_addr_t OBJ_OFFSET  = 22'h3_6000;
    localparam sdram_addr_t MAP_OFFSET  = 22'h5_6000;   // First word past the objects

endpackage

/* common/video_pkg.sv */
package video_pkg;

    typedef logic [8:0] vcnt_t;    // H or V position

    // Counter limits, both counters wrap to zero after these
    localparam vcnt_t HCNT_END = 9'h1ff;
    localparam vcnt_t VCNT_END = 9'h0ff;

    // Blanking windows
    // Active when the count is at or above start, or below end
    localparam vcnt_t HB_START = 9'h1c7;
    localparam vcnt_t HB_END   = 9'h04f;
    localparam vcnt_t VB_START = 9'h0f0;
    localparam vcnt_t VB_END   = 9'h010;

    // Sync pulses, same window rule for HS
    localparam vcnt_t HS_START = 9'h1f8;
    localparam vcnt_t HS_END   = 9'h020;
    localparam vcnt_t VS_START = 9'h0f8;    // VS runs to the end of the frame

    localparam int CEN_DIV = 6;             // 48 MHz clocks per pixel

endpackage

/* dwnld/dwnld_map.sv */
module dwnld_map (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 downloading,
    input  logic [24:0]          ioctl_addr,     // Byte address
    input  logic [7:0]           ioctl_data,
    input  logic                 ioctl_wr,
    input  logic                 sdram_ack,
    output rom_pkg::sdram_addr_t prog_addr,
    output logic [7:0]           prog_data,
    output logic [1:0]           prog_mask,      // Active low lane enables
    output logic                 prog_we
);
    import rom_pkg::*;

    sdram_addr_t word_addr;
    sdram_addr_t mapped_addr;
    logic        in_obj;
    logic        wr_start;

    assign word_addr = ioctl_addr[22:1];
    assign in_obj    = word_addr >= OBJ_OFFSET && word_addr < MAP_OFFSET;
    assign wr_start  = ioctl_wr && downloading;

    // Object tiles: bits 4..1 move up, old bit 5 lands on bit 1
    assign mapped_addr = in_obj ?
        {word_addr[21:6], word_addr[4:1], word_addr[5], word_addr[0]} : word_addr;

    always_ff @(posedge clk) begin
        if (wr_start) begin
            prog_addr <= mapped_addr;
            prog_data <= ioctl_data;
            prog_mask <= ioctl_addr[0] ? 2'b01 : 2'b10;    // Odd byte on the upper lane
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prog_we <= 1'b0;
        end else if (wr_start) begin
            prog_we <= 1'b1;
        end else if (sdram_ack) begin
            prog_we <= 1'b0;      // Held until the SDRAM takes it
        end
    end

endmodule

/* rom/rom_ctrl.sv */
module rom_ctrl (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 downloading,
    input  logic                 loop_rst,
    input  logic                 lvbl,
    input  logic                 main_req,
    input  rom_pkg::sdram_addr_t main_addr,
    input  logic                 char_req,
    input  rom_pkg::sdram_addr_t char_addr,
    output logic                 main_fill,
    output logic                 char_fill,
    output rom_pkg::sdram_data_t fill_data,
    output logic                 sdram_req,
    output rom_pkg::sdram_addr_t sdram_addr,
    input  logic                 sdram_ack,
    input  logic                 data_rdy,
    input  rom_pkg::sdram_data_t data_read,
    output logic                 refresh_en
);
    typedef enum logic [1:0] {
        st_idle,
        st_req,        // sdram_req high, waiting for ack
        st_wait_data
    } state_t;

    state_t state;
    logic   serve_main;    // Owner of the access in flight
    logic   rd_done;

    always_ff @(posedge clk) begin
        if (reset || loop_rst) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    // SDRAM belongs to the loader during download
                    if (!downloading && (main_req || char_req)) begin
                        state <= st_req;
                    end
                end
                st_req: begin
                    if (sdram_ack) begin
                        state <= st_wait_data;
                    end
                end
                st_wait_data: begin
                    if (data_rdy) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Grant latched while idle, main slot first
    always_ff @(posedge clk) begin
        if (state == st_idle) begin
            serve_main <= main_req;
            sdram_addr <= main_req ? main_addr : char_addr;
        end
    end

    assign sdram_req = state == st_req;
    assign rd_done   = state == st_wait_data && data_rdy;

    assign main_fill = rd_done && serve_main;
    assign char_fill = rd_done && !serve_main;
    assign fill_data = data_read;

    assign refresh_en = ~lvbl;    // Refresh only during vertical blank

endmodule

/* rom/rom_slot.sv */
module rom_slot #(
    parameter type                  data_t = logic [15:0],
    parameter int                   aw     = 14,
    parameter rom_pkg::sdram_addr_t offset = '0
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cs,
    input  logic [aw-1:0]        addr,
    output data_t                data,
    output logic                 ok,
    output logic                 miss_req,
    output rom_pkg::sdram_addr_t miss_addr,
    input  logic                 fill_we,
    input  rom_pkg::sdram_data_t fill_data
);
    import rom_pkg::*;

    logic [aw-1:0] cached_addr;
    logic [15:0]   cached_word;    // Only the low half of the read is kept
    logic          valid;
    logic          hit;

    assign hit      = valid && cached_addr == addr;
    assign ok       = cs && hit;
    assign miss_req = cs && !hit;  // Drops once the fill lands

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (fill_we) begin
            valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_we) begin
            cached_addr <= addr;      // Client holds addr until ok
            cached_word <= fill_data[15:0];
        end
    end

    if ($bits(data_t) == 8) begin : g_byte
        // Byte client, two bytes per SDRAM word
        assign miss_addr = offset + sdram_addr_t'(addr[aw-1:1]);
        assign data      = data_t'(addr[0] ? cached_word[15:8] : cached_word[7:0]);
    end else begin : g_word
        assign miss_addr = offset + sdram_addr_t'(addr);
        assign data      = data_t'(cached_word);
    end

endmodule

/* run_sim.sh */
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_sarms_game -f sources.f -o tb_sarms_game \
    && ./obj_dir/tb_sarms_game > sim.log 2>&1 \
    || echo "Build or simulation returned an error"
[ -f sim.log ] && cat sim.log
grep -q "^TESTS PASSED$" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

/* sim/sdram_model.sv */
module sdram_model (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 sdram_req,
    input  rom_pkg::sdram_addr_t sdram_addr,
    input  logic                 prog_we,
    output logic                 sdram_ack,
    output logic                 data_rdy,
    output rom_pkg::sdram_data_t data_read
);
    timeunit 1ns;
    timeprecision 1ps;

    import rom_pkg::*;

    logic [31:0] seed;
    logic [31:0] seed_nxt;
    logic [3:0]  wait_cnt;
    logic        busy;          // Read accepted, data still to come
    sdram_addr_t rd_addr;

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    assign seed_nxt = lcg_next(seed);

    always_ff @(posedge clk) begin
        if (reset) begin
            seed      <= 32'hf067;
            sdram_ack <= 1'b0;
            data_rdy  <= 1'b0;
            data_read <= '0;
            busy      <= 1'b0;
            wait_cnt  <= '0;
            rd_addr   <= '0;
        end else begin
            // One-cycle ack for reads and programming writes alike
            sdram_ack <= (sdram_req || prog_we) && !sdram_ack;
            data_rdy  <= 1'b0;
            if (sdram_req && !sdram_ack && !busy) begin
                seed     <= seed_nxt;
                busy     <= 1'b1;
                rd_addr  <= sdram_addr;
                wait_cnt <= {1'b0, seed_nxt[18:16]} + 4'd1;    // Data 2 to 9 cycles after ack
            end else if (busy) begin
                if (wait_cnt == '0) begin
                    busy      <= 1'b0;
                    data_rdy  <= 1'b1;
                    data_read <= {rd_addr[15:0], ~rd_addr[15:0]};
                end else begin
                    wait_cnt <= wait_cnt - 4'd1;
                end
            end
        end
    end

endmodule

/* sim/tb_sarms_game.sv */
module tb_sarms_game;
    timeunit 1ns;
    timeprecision 1ps;

    import video_pkg::*;
    import rom_pkg::*;

    typedef struct packed {
        logic        is_char;
        logic [16:0] addr;
        logic        rep;       // Same address again, must hit
    } rd_t;

    typedef struct packed {
        logic [24:0] addr;
        logic [7:0]  data;
        sdram_addr_t exp_addr;
        logic [1:0]  exp_mask;
    } dl_t;

    localparam int N_READS  = 9;
    localparam int N_WRITES = 7;
    localparam int FRAME_CYCLES = (int'(HCNT_END) + 1) * (int'(VCNT_END) + 1) * CEN_DIV;
    localparam int TIMEOUT_CYCLES = FRAME_CYCLES + CEN_DIV + 40 * (N_READS + N_WRITES + 3) + 5;

    rd_t reads [N_READS] = '{
        '{1'b0, 17'h00000, 1'b0},
        '{1'b0, 17'h00000, 1'b1},
        '{1'b0, 17'h00001, 1'b0},
        '{1'b1, 17'h00123, 1'b0},
        '{1'b1, 17'h00123, 1'b1},
        '{1'b0, 17'h1abcd, 1'b0},
        '{1'b1, 17'h03fff, 1'b0},
        '{1'b0, 17'h1abcd, 1'b1},    // Main cache survives the char access
        '{1'b0, 17'h0fff0, 1'b0}
    };

    // Object region words get bits 4..1 moved up and bit 5 on bit 1
    dl_t writes [N_WRITES] = '{
        '{25'h006c03f, 8'h3c, 22'h3603d, 2'b01},
        '{25'h006c040, 8'ha5, 22'h36002, 2'b10},
        '{25'h00abff4, 8'h5a, 22'h55ff6, 2'b10},
        '{25'h00ac001, 8'h81, 22'h56000, 2'b01},
        '{25'h006bffe, 8'h7e, 22'h35fff, 2'b10},
        '{25'h01002a5, 8'hc3, 22'h80152, 2'b01},
        '{25'h088c0a1, 8'h19, 22'h46060, 2'b01}    // Bit 23 is not part of the word
    };

    logic        clk = 1'b0;
    logic        reset;
    logic        pxl2_cen;
    logic        pxl_cen;
    logic        lhbl;
    logic        lvbl;
    logic        lhbl_dly;
    logic        lvbl_dly;
    logic        hs;
    logic        vs;
    logic        main_cs;
    logic [16:0] main_addr;
    main_data_t  main_data;
    logic        main_ok;
    logic        char_cs;
    logic [13:0] char_addr;
    char_data_t  char_data;
    logic        char_ok;
    logic        downloading;
    logic        dwnld_busy;
    logic        loop_rst;
    logic        sdram_req;
    sdram_addr_t sdram_addr;
    sdram_data_t data_read;
    logic        data_rdy;
    logic        sdram_ack;
    logic        refresh_en;
    logic [24:0] ioctl_addr;
    logic [7:0]  ioctl_data;
    logic        ioctl_wr;
    sdram_addr_t prog_addr;
    logic [7:0]  prog_data;
    logic [1:0]  prog_mask;
    logic        prog_we;
    logic        prog_rd;

    sarms_game i_sarms_game (.*);

    sdram_model u_sdram (
        .clk        ( clk        ),
        .reset      ( reset      ),
        .sdram_req  ( sdram_req  ),
        .sdram_addr ( sdram_addr ),
        .prog_we    ( prog_we    ),
        .sdram_ack  ( sdram_ack  ),
        .data_rdy   ( data_rdy   ),
        .data_read  ( data_read  )
    );

    always #4 clk = ~clk;    // 125 MHz stand-in for the 48 MHz clock

    task automatic abort_run();
        $display("TESTS FAILED");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_byte(string name, main_data_t exp, main_data_t act);
        if (act !== exp) begin
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_word(string name, char_data_t exp, char_data_t act);
        if (act !== exp) begin
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_addr(string name, sdram_addr_t exp, sdram_addr_t act);
        if (act !== exp) begin
            $display("Mismatch %s: expected %h, actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_mask(string name, logic [1:0] exp, logic [1:0] act);
        if (act !== exp) begin
            $display("Mismatch %s: expected %b, actual %b", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        if (act !== exp) begin
            $display("Mismatch %s: expected %b, actual %b", name, exp, act);
            abort_run();
        end
    endtask

    // Word address a client read should put on the SDRAM bus
    function automatic sdram_addr_t rom_word(logic is_char, logic [16:0] addr);
        if (is_char) begin
            return CHAR_OFFSET + sdram_addr_t'(addr[CHARW-1:0]);
        end
        return CPU_OFFSET + sdram_addr_t'(addr >> 1);
    endfunction

    // Starts at the negedge that releases reset
    task automatic check_frame();
        vcnt_t h;
        vcnt_t v;
        logic  prev_lhbl;
        logic  prev_lvbl;
        logic  exp_lhbl;
        logic  exp_lvbl;
        int    ph;
        int    k;
        h = '0;
        v = '0;
        prev_lhbl = 1'b0;
        prev_lvbl = 1'b0;
        for (k = 0; k < FRAME_CYCLES + CEN_DIV; k++) begin
            ph = k % CEN_DIV;
            exp_lhbl = !(h >= HB_START || h < HB_END);
            exp_lvbl = !(v >= VB_START || v < VB_END);
            check_flag("frame pxl_cen", ph == 0, pxl_cen);
            check_flag("frame pxl2_cen", ph == 0 || ph == CEN_DIV / 2, pxl2_cen);
            check_flag("frame lhbl", exp_lhbl, lhbl);
            check_flag("frame lvbl", exp_lvbl, lvbl);
            check_flag("frame hs", h >= HS_START || h < HS_END, hs);
            check_flag("frame vs", v >= VS_START, vs);
            check_flag("frame lhbl_dly", prev_lhbl, lhbl_dly);
            check_flag("frame lvbl_dly", prev_lvbl, lvbl_dly);
            check_flag("frame refresh_en", !exp_lvbl, refresh_en);
            if (ph == 0) begin
                prev_lhbl = exp_lhbl;
                prev_lvbl = exp_lvbl;
                if (h == HCNT_END) begin
                    v = (v == VCNT_END) ? '0 : v + 9'd1;
                end
                h = (h == HCNT_END) ? '0 : h + 9'd1;
            end
            @(negedge clk);
        end
    endtask

    task automatic drive_read(logic is_char, logic [16:0] addr);
        main_cs = !is_char;
        char_cs = is_char;
        if (is_char) begin
            char_addr = addr[CHARW-1:0];
        end else begin
            main_addr = addr;
        end
    endtask

    task automatic check_result(string name, logic is_char, logic [16:0] addr);
        sdram_addr_t w;
        logic [15:0] low;
        w = rom_word(is_char, addr);
        low = ~w[15:0];    // The slots keep the low half of the word
        if (is_char) begin
            check_flag({name, " char_ok"}, 1'b1, char_ok);
            check_word({name, " char_data"}, low, char_data);
        end else begin
            check_flag({name, " main_ok"}, 1'b1, main_ok);
            check_byte({name, " main_data"}, addr[0] ? low[15:8] : low[7:0], main_data);
        end
    endtask

    // Miss path, one SDRAM access and then ok
    task automatic wait_fill(string name, logic is_char, logic [16:0] addr);
        while (!sdram_req) begin
            @(negedge clk);
        end
        check_addr({name, " sdram_addr"}, rom_word(is_char, addr), sdram_addr);
        while (!(is_char ? char_ok : main_ok)) begin
            @(negedge clk);
        end
        check_result(name, is_char, addr);
    endtask

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Simulation hung, no end after %0d cycles", TIMEOUT_CYCLES);
        abort_run();
    end

    initial begin
        string name;
        int    i;
        reset       = 1'b1;
        loop_rst    = 1'b0;
        downloading = 1'b0;
        main_cs     = 1'b0;
        main_addr   = '0;
        char_cs     = 1'b0;
        char_addr   = '0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        ioctl_wr    = 1'b0;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        check_frame();

        for (i = 0; i < N_READS; i++) begin
            name = $sformatf("read %0d", i);
            drive_read(reads[i].is_char, reads[i].addr);
            @(negedge clk);
            if (reads[i].rep) begin
                repeat (3) begin
                    check_flag({name, " sdram_req"}, 1'b0, sdram_req);
                    check_result(name, reads[i].is_char, reads[i].addr);
                    @(negedge clk);
                end
            end else begin
                wait_fill(name, reads[i].is_char, reads[i].addr);
            end
        end

        // Both slots miss in the same cycle
        main_cs   = 1'b1;
        char_cs   = 1'b1;
        main_addr = 17'h02468;
        char_addr = 14'h2a5a;
        @(negedge clk);
        wait_fill("arbitration main", 1'b0, 17'h02468);
        wait_fill("arbitration char", 1'b1, 17'h02a5a);

        // A main miss is pending through the whole download
        char_cs     = 1'b0;
        main_addr   = 17'h05555;
        downloading = 1'b1;
        @(negedge clk);
        for (i = 0; i < N_WRITES; i++) begin
            name = $sformatf("write %0d", i);
            ioctl_addr = writes[i].addr;
            ioctl_data = writes[i].data;
            ioctl_wr   = 1'b1;
            @(negedge clk);
            ioctl_wr = 1'b0;
            check_flag({name, " prog_we"}, 1'b1, prog_we);
            check_addr({name, " prog_addr"}, writes[i].exp_addr, prog_addr);
            check_byte({name, " prog_data"}, writes[i].data, prog_data);
            check_mask({name, " prog_mask"}, writes[i].exp_mask, prog_mask);
            while (prog_we) begin
                check_flag({name, " sdram_req"}, 1'b0, sdram_req);
                check_flag({name, " dwnld_busy"}, 1'b1, dwnld_busy);
                check_flag({name, " prog_rd"}, 1'b0, prog_rd);
                @(negedge clk);
            end
        end
        downloading = 1'b0;
        @(negedge clk);
        check_flag("after download dwnld_busy", 1'b0, dwnld_busy);
        wait_fill("after download", 1'b0, 17'h05555);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

/* sources.f */
common/video_pkg.sv
common/rom_pkg.sv
src/cen_gen.sv
src/vtimer.sv
dwnld/dwnld_map.sv
rom/rom_slot.sv
rom/rom_ctrl.sv
src/sarms_game.sv
sim/sdram_model.sv
sim/tb_sarms_game.sv

/* src/cen_gen.sv */
module cen_gen (
    input  logic clk,
    input  logic reset,
    output logic pxl2_cen,    // 16 MHz
    output logic pxl_cen      // 8 MHz
);
    import video_pkg::*;

    typedef logic [$clog2(CEN_DIV)-1:0] cnt_t;

    cnt_t cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            cnt <= '0;
        end else if (cnt == cnt_t'(CEN_DIV - 1)) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // Half-pixel strobe at the start and the middle of each pixel
    assign pxl2_cen = cnt == '0 || cnt == cnt_t'(CEN_DIV / 2);
    assign pxl_cen  = cnt == '0;

endmodule

/* src/sarms_game.sv */
module sarms_game (
    input  logic                         clk,
    input  logic                         reset,
    output logic                         pxl2_cen,     // 16 MHz
    output logic                         pxl_cen,      // 8 MHz
    output logic                         lhbl,
    output logic                         lvbl,
    output logic                         lhbl_dly,
    output logic                         lvbl_dly,
    output logic                         hs,
    output logic                         vs,
    // Main CPU ROM
    input  logic                         main_cs,
    input  logic [rom_pkg::MAINW-1:0]    main_addr,
    output rom_pkg::main_data_t          main_data,
    output logic                         main_ok,
    // Character ROM
    input  logic                         char_cs,
    input  logic [rom_pkg::CHARW-1:0]    char_addr,
    output rom_pkg::char_data_t          char_data,
    output logic                         char_ok,
    // SDRAM
    input  logic                         downloading,
    output logic                         dwnld_busy,
    input  logic                         loop_rst,
    output logic                         sdram_req,
    output rom_pkg::sdram_addr_t         sdram_addr,
    input  rom_pkg::sdram_data_t         data_read,
    input  logic                         data_rdy,
    input  logic                         sdram_ack,
    output logic                         refresh_en,
    // ROM download
    input  logic [24:0]                  ioctl_addr,
    input  logic [7:0]                   ioctl_data,
    input  logic                         ioctl_wr,
    output rom_pkg::sdram_addr_t         prog_addr,
    output logic [7:0]                   prog_data,
    output logic [1:0]                   prog_mask,
    output logic                         prog_we,
    output logic                         prog_rd
);
    import rom_pkg::*;

    logic        main_miss;
    sdram_addr_t main_miss_addr;
    logic        main_fill;
    logic        char_miss;
    sdram_addr_t char_miss_addr;
    logic        char_fill;
    sdram_data_t fill_data;

    assign prog_rd    = 1'b0;      // No read back while loading
    assign dwnld_busy = downloading;

    cen_gen u_cen (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .pxl2_cen ( pxl2_cen ),
        .pxl_cen  ( pxl_cen  )
    );

    // Counters are not needed without the graphic layers
    vtimer u_timer (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .pxl_cen  ( pxl_cen  ),
        .h        (          ),
        .v        (          ),
        .lhbl     ( lhbl     ),
        .lvbl     ( lvbl     ),
        .lhbl_dly ( lhbl_dly ),
        .lvbl_dly ( lvbl_dly ),
        .hs       ( hs       ),
        .vs       ( vs       )
    );

    dwnld_map u_dwnld (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .ioctl_wr    ( ioctl_wr    ),
        .sdram_ack   ( sdram_ack   ),    // Shared with u_rom_ctrl
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .prog_we     ( prog_we     )
    );

    rom_slot #(
        .data_t ( main_data_t ),
        .aw     ( MAINW       ),
        .offset ( CPU_OFFSET  )
    ) u_main_slot (
        .clk       ( clk            ),
        .reset     ( reset          ),
        .cs        ( main_cs        ),
        .addr      ( main_addr      ),
        .data      ( main_data      ),
        .ok        ( main_ok        ),
        .miss_req  ( main_miss      ),
        .miss_addr ( main_miss_addr ),
        .fill_we   ( main_fill      ),
        .fill_data ( fill_data      )
    );

    rom_slot #(
        .data_t ( char_data_t ),
        .aw     ( CHARW       ),
        .offset ( CHAR_OFFSET )
    ) u_char_slot (
        .clk       ( clk            ),
        .reset     ( reset          ),
        .cs        ( char_cs        ),
        .addr      ( char_addr      ),
        .data      ( char_data      ),
        .ok        ( char_ok        ),
        .miss_req  ( char_miss      ),
        .miss_addr ( char_miss_addr ),
        .fill_we   ( char_fill      ),
        .fill_data ( fill_data      )
    );

    rom_ctrl u_rom_ctrl (
        .clk         ( clk            ),
        .reset       ( reset          ),
        .downloading ( downloading    ),
        .loop_rst    ( loop_rst       ),
        .lvbl        ( lvbl           ),
        .main_req    ( main_miss      ),
        .main_addr   ( main_miss_addr ),
        .char_req    ( char_miss      ),
        .char_addr   ( char_miss_addr ),
        .main_fill   ( main_fill      ),
        .char_fill   ( char_fill      ),
        .fill_data   ( fill_data      ),
        .sdram_req   ( sdram_req      ),
        .sdram_addr  ( sdram_addr     ),
        .sdram_ack   ( sdram_ack      ),
        .data_rdy    ( data_rdy       ),
        .data_read   ( data_read      ),
        .refresh_en  ( refresh_en     )
    );

endmodule

/* src/vtimer.sv */
module vtimer (
    input  logic             clk,
    input  logic             reset,
    input  logic             pxl_cen,
    output video_pkg::vcnt_t h,
    output video_pkg::vcnt_t v,
    output logic             lhbl,
    output logic             lvbl,
    output logic             lhbl_dly,
    output logic             lvbl_dly,
    output logic             hs,
    output logic             vs
);
    import video_pkg::*;

    vcnt_t h_nxt;
    vcnt_t v_nxt;

    // True inside a window that wraps around zero
    function automatic logic in_window(vcnt_t cnt, vcnt_t start, vcnt_t stop);
        return cnt >= start || cnt < stop;
    endfunction

    always_comb begin
        h_nxt = h + 1'b1;
        v_nxt = v;
        if (h == HCNT_END) begin
            h_nxt = '0;
            v_nxt = (v == VCNT_END) ? '0 : v + 1'b1;    // New line
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            h        <= '0;
            v        <= '0;
            lhbl     <= 1'b0;     // Position 0 is inside both blanks
            lvbl     <= 1'b0;
            lhbl_dly <= 1'b0;
            lvbl_dly <= 1'b0;
            hs       <= 1'b1;     // and inside the HS pulse
            vs       <= 1'b0;
        end else if (pxl_cen) begin
            h    <= h_nxt;
            v    <= v_nxt;
            // Flags follow the count they are registered with
            lhbl <= !in_window(h_nxt, HB_START, HB_END);
            lvbl <= !in_window(v_nxt, VB_START, VB_END);
            hs   <= in_window(h_nxt, HS_START, HS_END);
            vs   <= v_nxt >= VS_START;
            // One pixel late, lines up with the colour stage
            lhbl_dly <= lhbl;
            lvbl_dly <= lvbl;
        end
    end

endmodule
